//--- src/tcdm_pkg.sv
package tcdm_pkg;

  // ******************************
  // bus widths
  // ******************************

  // word width seen by cores and by every bank
  localparam int unsigned DataWidth = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth   = DataWidth / 8;
  // core byte address
  localparam int unsigned AddrWidth = 32;

  // atop field: bit 5 flags an atomic, bits 4..0 carry the risc-v funct5
  localparam int unsigned AtopWidth = 6;

  // ******************************
  // risc-v amo function codes
  // ******************************

  // add and swap are matched on all five bits
  localparam logic [4:0] AmoFunctAdd  = 5'h00;
  localparam logic [4:0] AmoFunctSwap = 5'h01;
  // the rest are told apart by bits 4..2 only
  localparam logic [4:0] AmoFunctXor  = 5'h04;
  localparam logic [4:0] AmoFunctOr   = 5'h08;
  localparam logic [4:0] AmoFunctAnd  = 5'h0C;
  localparam logic [4:0] AmoFunctMin  = 5'h10;
  localparam logic [4:0] AmoFunctMax  = 5'h14;
  localparam logic [4:0] AmoFunctMinu = 5'h18;
  localparam logic [4:0] AmoFunctMaxu = 5'h1C;

  // ******************************
  // shim operations
  // ******************************

  // AmoNone also covers lr, sc and unknown codes
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9
  } amo_op_e;

endpackage

//--- src/tcdm_req_xbar.sv
`timescale 1ns/100ps

module tcdm_req_xbar #(
  parameter int unsigned NumCores     = 4,
  parameter int unsigned NumBanks     = 8,
  parameter int unsigned AddrMemWidth = 8
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [NumCores-1:0]                                    core_req_i,
  input  logic [NumCores-1:0][tcdm_pkg::AddrWidth-1:0]           core_add_i,
  input  logic [NumCores-1:0]                                    core_we_i,
  input  logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0]           core_wdata_i,
  input  logic [NumCores-1:0][tcdm_pkg::BeWidth-1:0]             core_be_i,
  input  logic [NumCores-1:0][tcdm_pkg::AtopWidth-1:0]           core_atop_i,
  input  logic [NumBanks-1:0]                                    bank_gnt_i,
  output logic [NumCores-1:0]                                    core_gnt_o,
  output logic [NumBanks-1:0]                                    bank_req_o,
  output logic [NumBanks-1:0][AddrMemWidth-1:0]                  bank_row_o,
  output logic [NumBanks-1:0]                                    bank_we_o,
  output logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]           bank_wdata_o,
  output logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]             bank_be_o,
  output logic [NumBanks-1:0][tcdm_pkg::AtopWidth-1:0]           bank_atop_o,
  output logic [NumBanks-1:0][(NumCores > 1 ? $clog2(NumCores) : 1)-1:0] bank_winner_o
);

  localparam int unsigned BankSelWidth = $clog2(NumBanks);
  localparam int unsigned CoreIdxWidth = (NumCores > 1) ? $clog2(NumCores) : 1;

  // word interleaving: bits 1..0 are the byte offset, then bank, then row
  logic [NumCores-1:0][BankSelWidth-1:0] core_bank;
  logic [NumCores-1:0][AddrMemWidth-1:0] core_row;

  // one-hot grant per bank, folded per core below
  logic [NumBanks-1:0][NumCores-1:0]     bank_core_gnt;

  for (genvar c = 0; c < NumCores; c++) begin : gen_decode
    assign core_bank[c] = core_add_i[c][2 +: BankSelWidth];
    assign core_row[c]  = core_add_i[c][2 + BankSelWidth +: AddrMemWidth];
  end

  // ******************************
  // per-bank round-robin arbiter
  // ******************************
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic [NumCores-1:0]     hit;
    logic                    found;
    logic [CoreIdxWidth-1:0] winner;
    logic [CoreIdxWidth-1:0] rr_q;

    always_comb begin
      for (int unsigned c = 0; c < NumCores; c++) begin
        hit[c] = core_req_i[c] && (core_bank[c] == BankSelWidth'(b));
      end
    end

    // scan from the pointer upwards and take the first requester
    always_comb begin
      int unsigned idx;
      found  = 1'b0;
      winner = rr_q;
      for (int unsigned i = 0; i < NumCores; i++) begin
        idx = rr_q + i;
        if (idx >= NumCores) begin
          idx = idx - NumCores;
        end
        if (!found && hit[idx]) begin
          found  = 1'b1;
          winner = CoreIdxWidth'(idx);
        end
      end
    end

    // pointer only moves when the bank actually takes the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (found && bank_gnt_i[b]) begin
        if (winner == CoreIdxWidth'(NumCores - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= winner + 1'b1;
        end
      end
    end

    assign bank_req_o[b]    = found;
    assign bank_winner_o[b] = winner;
    assign bank_row_o[b]    = core_row[winner];
    assign bank_we_o[b]     = core_we_i[winner];
    assign bank_wdata_o[b]  = core_wdata_i[winner];
    assign bank_be_o[b]     = core_be_i[winner];
    assign bank_atop_o[b]   = core_atop_i[winner];

    assign bank_core_gnt[b] = (found && bank_gnt_i[b]) ? (NumCores'(1) << winner) : '0;
  end

  // a core targets one bank, so at most one bit per core is set
  always_comb begin
    core_gnt_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      core_gnt_o = core_gnt_o | bank_core_gnt[b];
    end
  end

endmodule

//--- src/tcdm_amo_shim.sv
`timescale 1ns/100ps

module tcdm_amo_shim #(
  parameter int unsigned AddrMemWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // crossbar side
  input  logic                           req_i,
  input  logic [AddrMemWidth-1:0]        row_i,
  input  logic                           we_i,
  input  logic [tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   be_i,
  input  logic [tcdm_pkg::AtopWidth-1:0] atop_i,
  output logic                           gnt_o,
  output logic [tcdm_pkg::DataWidth-1:0] rdata_o,
  // sram side
  output logic                           sram_req_o,
  output logic                           sram_we_o,
  output logic [AddrMemWidth-1:0]        sram_add_o,
  output logic [tcdm_pkg::DataWidth-1:0] sram_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]   sram_be_o,
  input  logic [tcdm_pkg::DataWidth-1:0] sram_rdata_i
);

  tcdm_pkg::amo_op_e              amo_op;
  logic                           amo_start;
  logic                           busy_q;
  tcdm_pkg::amo_op_e              op_q;
  logic [AddrMemWidth-1:0]        row_q;
  logic [tcdm_pkg::DataWidth-1:0] operand_q;
  logic [tcdm_pkg::DataWidth-1:0] amo_result;

  // ******************************
  // atop to amo translation
  // ******************************
  always_comb begin
    amo_op = tcdm_pkg::AmoNone;
    if (atop_i[5]) begin
      if (atop_i[4:0] == tcdm_pkg::AmoFunctAdd) begin
        amo_op = tcdm_pkg::AmoAdd;
      end else if (atop_i[4:0] == tcdm_pkg::AmoFunctSwap) begin
        amo_op = tcdm_pkg::AmoSwap;
      end else begin
        // lr and sc fall through here and stay plain accesses
        case (atop_i[4:2])
          tcdm_pkg::AmoFunctXor[4:2]:  amo_op = tcdm_pkg::AmoXor;
          tcdm_pkg::AmoFunctOr[4:2]:   amo_op = tcdm_pkg::AmoOr;
          tcdm_pkg::AmoFunctAnd[4:2]:  amo_op = tcdm_pkg::AmoAnd;
          tcdm_pkg::AmoFunctMin[4:2]:  amo_op = tcdm_pkg::AmoMin;
          tcdm_pkg::AmoFunctMax[4:2]:  amo_op = tcdm_pkg::AmoMax;
          tcdm_pkg::AmoFunctMinu[4:2]: amo_op = tcdm_pkg::AmoMinu;
          tcdm_pkg::AmoFunctMaxu[4:2]: amo_op = tcdm_pkg::AmoMaxu;
          default:                     amo_op = tcdm_pkg::AmoNone;
        endcase
      end
    end
  end

  assign gnt_o     = !busy_q;
  assign amo_start = req_i && !busy_q && (amo_op != tcdm_pkg::AmoNone);

  // ******************************
  // read-modify-write sequencing
  // ******************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      // the write phase always lasts exactly one cycle
      busy_q <= amo_start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (amo_start) begin
      op_q      <= amo_op;
      row_q     <= row_i;
      operand_q <= wdata_i;
    end
  end

  // sram_rdata_i holds the old word during the write phase
  always_comb begin
    case (op_q)
      tcdm_pkg::AmoSwap: amo_result = operand_q;
      tcdm_pkg::AmoAdd:  amo_result = sram_rdata_i + operand_q;
      tcdm_pkg::AmoAnd:  amo_result = sram_rdata_i & operand_q;
      tcdm_pkg::AmoOr:   amo_result = sram_rdata_i | operand_q;
      tcdm_pkg::AmoXor:  amo_result = sram_rdata_i ^ operand_q;
      tcdm_pkg::AmoMax:
        amo_result = ($signed(sram_rdata_i) > $signed(operand_q)) ? sram_rdata_i : operand_q;
      tcdm_pkg::AmoMaxu: amo_result = (sram_rdata_i > operand_q) ? sram_rdata_i : operand_q;
      tcdm_pkg::AmoMin:
        amo_result = ($signed(sram_rdata_i) < $signed(operand_q)) ? sram_rdata_i : operand_q;
      tcdm_pkg::AmoMinu: amo_result = (sram_rdata_i < operand_q) ? sram_rdata_i : operand_q;
      default:           amo_result = sram_rdata_i;
    endcase
  end

  always_comb begin
    sram_req_o   = 1'b0;
    sram_we_o    = 1'b0;
    sram_add_o   = row_i;
    sram_wdata_o = wdata_i;
    sram_be_o    = be_i;
    if (busy_q) begin
      // write back the computed word
      sram_req_o   = 1'b1;
      sram_we_o    = 1'b1;
      sram_add_o   = row_q;
      sram_wdata_o = amo_result;
      sram_be_o    = '1;
    end else if (req_i) begin
      sram_req_o = 1'b1;
      if (amo_op != tcdm_pkg::AmoNone) begin
        // first phase of an atomic is a full-word read
        sram_be_o = '1;
      end else begin
        sram_we_o = we_i;
      end
    end
  end

  // old word for atomics, read data for plain accesses
  assign rdata_o = sram_rdata_i;

endmodule

//--- src/tcdm_resp_router.sv
`timescale 1ns/100ps

module tcdm_resp_router #(
  parameter int unsigned NumCores = 4,
  parameter int unsigned NumBanks = 8
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [NumBanks-1:0]                                    bank_req_i,
  input  logic [NumBanks-1:0]                                    bank_gnt_i,
  input  logic [NumBanks-1:0][(NumCores > 1 ? $clog2(NumCores) : 1)-1:0] bank_winner_i,
  input  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]           bank_rdata_i,
  output logic [NumCores-1:0]                                    core_r_valid_o,
  output logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0]           core_r_rdata_o
);

  localparam int unsigned CoreIdxWidth = (NumCores > 1) ? $clog2(NumCores) : 1;

  // which banks took an access last cycle, and for whom
  logic [NumBanks-1:0]                   served_q;
  logic [NumBanks-1:0][CoreIdxWidth-1:0] winner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      served_q <= '0;
    end else begin
      served_q <= bank_req_i & bank_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    winner_q <= bank_winner_i;
  end

  // ******************************
  // response steering
  // ******************************

  // a core wins at most one bank per cycle, so no two banks hit one core
  always_comb begin
    core_r_valid_o = '0;
    core_r_rdata_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (served_q[b]) begin
        core_r_valid_o[winner_q[b]] = 1'b1;
        core_r_rdata_o[winner_q[b]] = bank_rdata_i[b];
      end
    end
  end

endmodule

//--- src/tcdm_interconnect.sv
`timescale 1ns/100ps

module tcdm_interconnect #(
  parameter int unsigned NumCores     = 4,
  parameter int unsigned NumBanks     = 8,
  parameter int unsigned AddrMemWidth = 8
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // cores
  input  logic [NumCores-1:0]                          core_req_i,
  input  logic [NumCores-1:0][tcdm_pkg::AddrWidth-1:0] core_add_i,
  input  logic [NumCores-1:0]                          core_we_i,
  input  logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0] core_wdata_i,
  input  logic [NumCores-1:0][tcdm_pkg::BeWidth-1:0]   core_be_i,
  input  logic [NumCores-1:0][tcdm_pkg::AtopWidth-1:0] core_atop_i,
  output logic [NumCores-1:0]                          core_gnt_o,
  output logic [NumCores-1:0]                          core_r_valid_o,
  output logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0] core_r_rdata_o,
  // sram banks
  output logic [NumBanks-1:0]                          sram_req_o,
  output logic [NumBanks-1:0]                          sram_we_o,
  output logic [NumBanks-1:0][AddrMemWidth-1:0]        sram_add_o,
  output logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] sram_wdata_o,
  output logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   sram_be_o,
  input  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] sram_rdata_i
);

  localparam int unsigned CoreIdxWidth = (NumCores > 1) ? $clog2(NumCores) : 1;

  // crossbar to shims
  logic [NumBanks-1:0]                          bank_req;
  logic [NumBanks-1:0]                          bank_gnt;
  logic [NumBanks-1:0][AddrMemWidth-1:0]        bank_row;
  logic [NumBanks-1:0]                          bank_we;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_wdata;
  logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   bank_be;
  logic [NumBanks-1:0][tcdm_pkg::AtopWidth-1:0] bank_atop;
  // crossbar and shims to router
  logic [NumBanks-1:0][CoreIdxWidth-1:0]        bank_winner;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_rdata;

  tcdm_req_xbar #(
    .NumCores     ( NumCores     ),
    .NumBanks     ( NumBanks     ),
    .AddrMemWidth ( AddrMemWidth )
  ) i_req_xbar (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .core_req_i    ( core_req_i   ),
    .core_add_i    ( core_add_i   ),
    .core_we_i     ( core_we_i    ),
    .core_wdata_i  ( core_wdata_i ),
    .core_be_i     ( core_be_i    ),
    .core_atop_i   ( core_atop_i  ),
    .bank_gnt_i    ( bank_gnt     ),
    .core_gnt_o    ( core_gnt_o   ),
    .bank_req_o    ( bank_req     ),
    .bank_row_o    ( bank_row     ),
    .bank_we_o     ( bank_we      ),
    .bank_wdata_o  ( bank_wdata   ),
    .bank_be_o     ( bank_be      ),
    .bank_atop_o   ( bank_atop    ),
    .bank_winner_o ( bank_winner  )
  );

  // ******************************
  // one atomic shim per bank
  // ******************************
  for (genvar b = 0; b < NumBanks; b++) begin : gen_shim
    tcdm_amo_shim #(
      .AddrMemWidth ( AddrMemWidth )
    ) i_amo_shim (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .req_i        ( bank_req[b]     ),
      .row_i        ( bank_row[b]     ),
      .we_i         ( bank_we[b]      ),
      .wdata_i      ( bank_wdata[b]   ),
      .be_i         ( bank_be[b]      ),
      .atop_i       ( bank_atop[b]    ),
      .gnt_o        ( bank_gnt[b]     ),
      .rdata_o      ( bank_rdata[b]   ),
      .sram_req_o   ( sram_req_o[b]   ),
      .sram_we_o    ( sram_we_o[b]    ),
      .sram_add_o   ( sram_add_o[b]   ),
      .sram_wdata_o ( sram_wdata_o[b] ),
      .sram_be_o    ( sram_be_o[b]    ),
      .sram_rdata_i ( sram_rdata_i[b] )
    );
  end

  tcdm_resp_router #(
    .NumCores ( NumCores ),
    .NumBanks ( NumBanks )
  ) i_resp_router (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .bank_req_i     ( bank_req       ),
    .bank_gnt_i     ( bank_gnt       ),
    .bank_winner_i  ( bank_winner    ),
    .bank_rdata_i   ( bank_rdata     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o )
  );

endmodule

//--- tb/tcdm_bank_model.sv
`timescale 1ns/100ps

module tcdm_bank_model #(
  parameter int unsigned NumBanks     = 8,
  parameter int unsigned AddrMemWidth = 8
) (
  input  logic                                         clk_i,
  input  logic [NumBanks-1:0]                          req_i,
  input  logic [NumBanks-1:0]                          we_i,
  input  logic [NumBanks-1:0][AddrMemWidth-1:0]        add_i,
  input  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   be_i,
  output logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned Rows = 2 ** AddrMemWidth;

  logic [tcdm_pkg::DataWidth-1:0] mem [NumBanks][Rows];

  // fill pattern built from bank and row, so every word starts out distinct
  initial begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned r = 0; r < Rows; r++) begin
        mem[b][r] = {8'h5a ^ 8'(b), 8'(r), 8'(b * 37 + r), 8'h3c};
      end
    end
  end

  // one read cycle of latency, rdata keeps its value on writes
  always @(posedge clk_i) begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (req_i[b]) begin
        if (we_i[b]) begin
          for (int unsigned i = 0; i < tcdm_pkg::BeWidth; i++) begin
            if (be_i[b][i]) begin
              mem[b][add_i[b]][8*i +: 8] <= wdata_i[b][8*i +: 8];
            end
          end
        end else begin
          rdata_o[b] <= mem[b][add_i[b]];
        end
      end
    end
  end

endmodule

//--- tb/tb_tcdm_interconnect.sv
`timescale 1ns/100ps

module tb_tcdm_interconnect;

  localparam int unsigned NumCores     = 4;
  localparam int unsigned NumBanks     = 8;
  localparam int unsigned AddrMemWidth = 8;
  localparam int unsigned Rows         = 2 ** AddrMemWidth;
  localparam int unsigned BankBits     = $clog2(NumBanks);
  localparam int unsigned Timeout      = 40;
  localparam logic [31:0] LfsrTaps     = 32'h8020_0003;

  // the last three entries are lr, sc and an amo code with bit 5 cleared
  localparam logic [5:0] AtopList [12] = '{
    {1'b1, tcdm_pkg::AmoFunctAdd},  {1'b1, tcdm_pkg::AmoFunctSwap},
    {1'b1, tcdm_pkg::AmoFunctXor},  {1'b1, tcdm_pkg::AmoFunctOr},
    {1'b1, tcdm_pkg::AmoFunctAnd},  {1'b1, tcdm_pkg::AmoFunctMin},
    {1'b1, tcdm_pkg::AmoFunctMax},  {1'b1, tcdm_pkg::AmoFunctMinu},
    {1'b1, tcdm_pkg::AmoFunctMaxu}, {1'b1, 5'h02},
    {1'b1, 5'h03},                  {1'b0, tcdm_pkg::AmoFunctMax}
  };

  logic                                         clk_i;
  logic                                         rst_ni;
  logic [NumCores-1:0]                          core_req_i;
  logic [NumCores-1:0][tcdm_pkg::AddrWidth-1:0] core_add_i;
  logic [NumCores-1:0]                          core_we_i;
  logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0] core_wdata_i;
  logic [NumCores-1:0][tcdm_pkg::BeWidth-1:0]   core_be_i;
  logic [NumCores-1:0][tcdm_pkg::AtopWidth-1:0] core_atop_i;
  logic [NumCores-1:0]                          core_gnt_o;
  logic [NumCores-1:0]                          core_r_valid_o;
  logic [NumCores-1:0][tcdm_pkg::DataWidth-1:0] core_r_rdata_o;
  logic [NumBanks-1:0]                          sram_req;
  logic [NumBanks-1:0]                          sram_we;
  logic [NumBanks-1:0][AddrMemWidth-1:0]        sram_add;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] sram_wdata;
  logic [NumBanks-1:0][tcdm_pkg::BeWidth-1:0]   sram_be;
  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] sram_rdata;

  logic [31:0]         lfsr;
  logic [31:0]         shadow [NumBanks][Rows];
  logic [NumCores-1:0] pend_valid;
  logic [NumCores-1:0] pend_check;
  logic [31:0]         pend_rdata [NumCores];
  int unsigned         mismatch_errors;
  int unsigned         other_errors;

  tcdm_interconnect #(
    .NumCores     ( NumCores     ),
    .NumBanks     ( NumBanks     ),
    .AddrMemWidth ( AddrMemWidth )
  ) UUT (
    .clk_i, .rst_ni, .core_req_i, .core_add_i, .core_we_i, .core_wdata_i, .core_be_i,
    .core_atop_i, .core_gnt_o, .core_r_valid_o, .core_r_rdata_o,
    .sram_req_o   ( sram_req   ),
    .sram_we_o    ( sram_we    ),
    .sram_add_o   ( sram_add   ),
    .sram_wdata_o ( sram_wdata ),
    .sram_be_o    ( sram_be    ),
    .sram_rdata_i ( sram_rdata )
  );

  tcdm_bank_model #(
    .NumBanks     ( NumBanks     ),
    .AddrMemWidth ( AddrMemWidth )
  ) i_bank_model (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .add_i   ( sram_add   ),
    .wdata_i ( sram_wdata ),
    .be_i    ( sram_be    ),
    .rdata_o ( sram_rdata )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  // ******************************
  // helpers
  // ******************************

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // the decoder must ignore the random upper bits
  function automatic logic [31:0] rand_addr();
    return take_bits(30) << 2;
  endfunction

  function automatic logic [31:0] with_bank(input logic [31:0] add, input int unsigned bank);
    logic [31:0] res;
    res = add;
    res[2 +: BankBits] = BankBits'(bank);
    return res;
  endfunction

  // same pattern as the bank model starts with
  function automatic logic [31:0] fill_word(input int unsigned b, input int unsigned r);
    return {8'h5a ^ 8'(b), 8'(r), 8'(b * 37 + r), 8'h3c};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] res;
    res = old_word;
    for (int unsigned i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // lr (00010) and sc (00011) are not atomics here
  function automatic logic is_amo_code(input logic [5:0] atop);
    return atop[5] && ((atop[4:0] <= 5'h01) || (atop[4:2] != 3'd0));
  endfunction

  function automatic logic [31:0] amo_expect(input logic [4:0] funct,
                                             input logic [31:0] old_word,
                                             input logic [31:0] operand);
    logic [31:0] res;
    res = old_word;
    if (funct == 5'h00) begin
      res = old_word + operand;
    end else if (funct == 5'h01) begin
      res = operand;
    end else begin
      case (funct[4:2])
        3'd1:    res = old_word ^ operand;
        3'd2:    res = old_word | operand;
        3'd3:    res = old_word & operand;
        3'd4:    res = ($signed(old_word) < $signed(operand)) ? old_word : operand;
        3'd5:    res = ($signed(old_word) > $signed(operand)) ? old_word : operand;
        3'd6:    res = (old_word < operand) ? old_word : operand;
        3'd7:    res = (old_word > operand) ? old_word : operand;
        default: res = old_word;
      endcase
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    other_errors++;
    $display("%s", why);
    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic drive_core(input int unsigned c, input logic [31:0] add, input logic we,
                            input logic [31:0] wdata, input logic [3:0] be,
                            input logic [5:0] atop);
    core_add_i[c]   = add;
    core_we_i[c]    = we;
    core_wdata_i[c] = wdata;
    core_be_i[c]    = be;
    core_atop_i[c]  = atop;
    core_req_i[c]   = 1'b1;
  endtask

  // returns 1 ns after the grant edge with the request dropped
  task automatic wait_gnt(input int unsigned c);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (!core_gnt_o[c] && (waited < Timeout)) begin
      waited++;
      @(negedge clk_i);
    end
    if (!core_gnt_o[c]) begin
      abort_run($sformatf("timeout: core %0d was never granted", c));
    end else begin
      @(posedge clk_i);
      #1;
      core_req_i[c] = 1'b0;
    end
  endtask

  task automatic access(input int unsigned c, input logic [31:0] add, input logic we,
                        input logic [31:0] wdata, input logic [3:0] be, input logic [5:0] atop);
    drive_core(c, add, we, wdata, be, atop);
    wait_gnt(c);
  endtask

  // ******************************
  // response monitor
  // ******************************

  // grants seen at a falling edge take effect at the next rising edge
  always @(negedge clk_i) begin : monitor
    logic [31:0] old_word;
    int unsigned bank;
    int unsigned row;
    if (!rst_ni) begin
      assert (core_r_valid_o == '0) else begin
        mismatch_errors++;
        $display("MISMATCH core_r_valid_o in reset: got %h expected %h",
                 core_r_valid_o, NumCores'(0));
      end
      pend_valid = '0;
    end else begin
      for (int unsigned c = 0; c < NumCores; c++) begin
        assert (core_r_valid_o[c] == pend_valid[c]) else begin
          mismatch_errors++;
          $display("MISMATCH core_r_valid_o[%0d]: got %h expected %h",
                   c, core_r_valid_o[c], pend_valid[c]);
        end
        if (pend_valid[c] && pend_check[c]) begin
          assert (core_r_rdata_o[c] == pend_rdata[c]) else begin
            mismatch_errors++;
            $display("MISMATCH core_r_rdata_o[%0d]: got %h expected %h",
                     c, core_r_rdata_o[c], pend_rdata[c]);
          end
        end
      end
      assert ((core_gnt_o & ~core_req_i) == '0) else begin
        other_errors++;
        $display("a core was granted without requesting: gnt %h req %h", core_gnt_o, core_req_i);
      end
      for (int unsigned c = 0; c < NumCores; c++) begin
        pend_valid[c] = core_gnt_o[c];
        pend_check[c] = 1'b0;
        if (core_gnt_o[c]) begin
          bank     = core_add_i[c][2 +: BankBits];
          row      = core_add_i[c][2 + BankBits +: AddrMemWidth];
          old_word = shadow[bank][row];
          if (is_amo_code(core_atop_i[c])) begin
            pend_check[c]     = 1'b1;
            pend_rdata[c]     = old_word;
            shadow[bank][row] = amo_expect(core_atop_i[c][4:0], old_word, core_wdata_i[c]);
          end else if (core_we_i[c]) begin
            shadow[bank][row] = merge_bytes(old_word, core_wdata_i[c], core_be_i[c]);
          end else begin
            pend_check[c] = 1'b1;
            pend_rdata[c] = old_word;
          end
        end
      end
    end
  end

  // ******************************
  // directed scenarios
  // ******************************

  // every window of NumCores grants on a shared bank covers all cores
  task automatic fairness_run();
    logic [NumCores-1:0] seen;
    int unsigned         grants;
    int unsigned         waited;
    int unsigned         bank;
    bank = take_bits(BankBits);
    for (int unsigned c = 0; c < NumCores; c++) begin
      drive_core(c, with_bank(rand_addr(), bank), 1'b0, 32'h0, 4'hf, 6'h00);
    end
    seen   = '0;
    grants = 0;
    waited = 0;
    while (grants < 2 * NumCores) begin
      @(negedge clk_i);
      if (waited == Timeout) begin
        abort_run("timeout: the shared bank stopped granting requests");
      end else begin
        waited++;
        assert ($countones(core_gnt_o) <= 1) else begin
          other_errors++;
          $display("one bank granted %0d cores in the same cycle", $countones(core_gnt_o));
        end
        for (int unsigned c = 0; c < NumCores; c++) begin
          if (core_gnt_o[c]) begin
            assert (!seen[c]) else begin
              other_errors++;
              $display("core %0d was granted twice while another core waited", c);
            end
            seen[c] = 1'b1;
            grants++;
            waited = 0;
          end
        end
        if (seen == '1) begin
          seen = '0;
        end
      end
    end
    @(posedge clk_i);
    #1;
    core_req_i = '0;
  endtask

  task automatic parallel_banks();
    logic [31:0] data;
    for (int unsigned c = 0; c < NumCores; c++) begin
      data = take_bits(32);
      drive_core(c, with_bank(rand_addr(), c % NumBanks), 1'b1, data, 4'hf, 6'h00);
    end
    @(negedge clk_i);
    assert (core_gnt_o == '1) else begin
      other_errors++;
      $display("cores on separate banks were not granted together: gnt %h", core_gnt_o);
    end
    @(posedge clk_i);
    #1;
    core_req_i = '0;
  endtask

  // the write phase of an atomic blocks its bank for exactly one cycle
  task automatic atomic_stall();
    logic [31:0] add;
    logic [31:0] data;
    add  = rand_addr();
    data = take_bits(32);
    access(0, add, 1'b0, data, 4'hf, {1'b1, tcdm_pkg::AmoFunctAdd});
    drive_core(1, add, 1'b0, 32'h0, 4'hf, 6'h00);
    @(negedge clk_i);
    assert (!core_gnt_o[1]) else begin
      other_errors++;
      $display("core 1 was granted during the atomic write cycle");
    end
    @(negedge clk_i);
    assert (core_gnt_o[1]) else begin
      other_errors++;
      $display("core 1 was not granted in the cycle after the atomic write");
    end
    @(posedge clk_i);
    #1;
    core_req_i[1] = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] add;
    logic [31:0] data;
    logic [3:0]  be;
    logic [5:0]  atop;
    int unsigned c;
    lfsr            = 32'h8f16_0109;
    mismatch_errors = 0;
    other_errors    = 0;
    pend_valid      = '0;
    pend_check      = '0;
    core_add_i      = '0;
    core_we_i       = '0;
    core_wdata_i    = '0;
    core_be_i       = '0;
    core_atop_i     = '0;
    // reads held through reset must not produce any response
    core_req_i      = '1;
    rst_ni          = 1'b0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned r = 0; r < Rows; r++) begin
        shadow[b][r] = fill_word(b, r);
      end
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni     = 1'b1;
    core_req_i = '0;

    // untouched read, full write, read back
    for (int unsigned k = 0; k < NumCores * 4; k++) begin
      c    = k % NumCores;
      add  = rand_addr();
      data = take_bits(32);
      access(c, add, 1'b0, 32'h0, 4'hf, 6'h00);
      access(c, add, 1'b1, data, 4'hf, 6'h00);
      access(c, add, 1'b0, 32'h0, 4'hf, 6'h00);
    end

    // partial writes over a known word
    for (int unsigned k = 0; k < NumCores * 3; k++) begin
      c    = k % NumCores;
      add  = rand_addr();
      data = take_bits(32);
      access(c, add, 1'b1, data, 4'hf, 6'h00);
      data = take_bits(32);
      be   = take_bits(4);
      access(c, add, 1'b1, data, be, 6'h00);
      access(c, add, 1'b0, 32'h0, 4'hf, 6'h00);
    end

    // every atop code on a random old word followed by a read of the result
    for (int unsigned k = 0; k < 24; k++) begin
      c    = (k + k / 12) % NumCores;
      add  = rand_addr();
      data = take_bits(32);
      access(c, add, 1'b1, data, 4'hf, 6'h00);
      data = take_bits(32);
      atop = AtopList[k % 12];
      access(c, add, atop != {1'b1, 5'h02}, data, 4'hf, atop);
      access(c, add, 1'b0, 32'h0, 4'hf, 6'h00);
    end

    fairness_run();
    parallel_banks();
    atomic_stall();
    repeat (3) @(negedge clk_i);

    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
src/tcdm_pkg.sv
src/tcdm_req_xbar.sv
src/tcdm_amo_shim.sv
src/tcdm_resp_router.sv
src/tcdm_interconnect.sv
tb/tcdm_bank_model.sv
tb/tb_tcdm_interconnect.sv

//--- run_sim.sh
#!/bin/sh
# build and run the TCDM interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_tcdm_interconnect \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
